//--- logic/beam_defines.svh
/*
  widths and counts shared by the beamforming combiner
  weights are signed Q1.7, so the product shift equals the fraction width
  BEAM_PROD_W and BEAM_SUM_W must hold the shifted product and the four-channel sum
  queue depth is also the credit count upstream starts with
*/
`ifndef BEAM_DEFINES_SVH
`define BEAM_DEFINES_SVH

// sample and weight component widths
`define BEAM_SAMPLE_W 16
`define BEAM_WEIGHT_W 8
`define BEAM_WEIGHT_FRAC 7

// beat geometry
`define BEAM_LANES 8
`define BEAM_CHANNELS 4

// internal arithmetic widths, product after the Q1.7 shift and channel sum
`define BEAM_PROD_W 18
`define BEAM_SUM_W 20

// flow control, upstream credits equal the queue depth
`define BEAM_QUEUE_DEPTH 4
`define BEAM_OUT_CREDITS 2

`endif

//--- logic/beam_pkg.sv
/*
  data types of the beamforming combiner
  all complex values keep real and imaginary parts as signed fields
  lane 0 sits in the low bits of every beat
*/
`include "beam_defines.svh"

package beam_pkg;

    // one complex input or output sample
    typedef struct packed {
        logic signed [`BEAM_SAMPLE_W-1:0] re;
        logic signed [`BEAM_SAMPLE_W-1:0] im;
    } cplx_sample_t;

    // complex weight, both parts in Q1.7
    typedef struct packed {
        logic signed [`BEAM_WEIGHT_W-1:0] re;
        logic signed [`BEAM_WEIGHT_W-1:0] im;
    } cplx_weight_t;

    // weighted sample after the arithmetic shift, still wider than a sample
    typedef struct packed {
        logic signed [`BEAM_PROD_W-1:0] re;
        logic signed [`BEAM_PROD_W-1:0] im;
    } cplx_prod_t;

    typedef struct packed {
        cplx_sample_t [`BEAM_LANES-1:0] lane;
    } channel_beat_t;

    // input beat, every channel for one time slot
    typedef struct packed {
        channel_beat_t [`BEAM_CHANNELS-1:0] chan;
        logic last;
    } array_beat_t;

    typedef struct packed {
        cplx_weight_t [`BEAM_CHANNELS-1:0] chan;
    } weight_set_t;

    // record between the weight stage and the sum stage
    typedef struct packed {
        cplx_prod_t [`BEAM_CHANNELS-1:0][`BEAM_LANES-1:0] prod;
        logic last;
    } weighted_beat_t;

    // combined output beat
    typedef struct packed {
        cplx_sample_t [`BEAM_LANES-1:0] lane;
        logic last;
    } beam_beat_t;

endpackage

//--- logic/beam_weight_stage.sv
/*
  first pipeline stage, complex weighting of every lane of every channel
  weights are sampled on the same edge as the beat and are expected to be static
  products are floor divided by 128, no rounding
  one cycle latency, takes a beat every cycle and never stalls
*/
`include "beam_defines.svh"

module beam_weight_stage (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       in_valid,
    input  beam_pkg::array_beat_t      in_beat,
    input  beam_pkg::weight_set_t      weights,
    output logic                       prod_valid,
    output beam_pkg::weighted_beat_t   prod_beat
);

    // a sample times a weight, plus one bit for the sum of two such terms
    localparam int ACC_W = `BEAM_SAMPLE_W + `BEAM_WEIGHT_W + 1;

    beam_pkg::weighted_beat_t prod_next;

    for (genvar c = 0; c < `BEAM_CHANNELS; c++) begin : g_chan
        for (genvar l = 0; l < `BEAM_LANES; l++) begin : g_lane
            logic signed [ACC_W-1:0] acc_re;
            logic signed [ACC_W-1:0] acc_im;

            // full precision complex multiply, all operands are signed so
            // they extend to the accumulator width before the multiply
            assign acc_re = in_beat.chan[c].lane[l].re * weights.chan[c].re
                          - in_beat.chan[c].lane[l].im * weights.chan[c].im;
            assign acc_im = in_beat.chan[c].lane[l].re * weights.chan[c].im
                          + in_beat.chan[c].lane[l].im * weights.chan[c].re;

            // dropping the fraction bits of a two's complement value is an
            // arithmetic shift, which rounds toward minus infinity
            // the remaining slice is exactly the product width
            assign prod_next.prod[c][l].re = acc_re[`BEAM_WEIGHT_FRAC +: `BEAM_PROD_W];
            assign prod_next.prod[c][l].im = acc_im[`BEAM_WEIGHT_FRAC +: `BEAM_PROD_W];
        end
    end

    // frame end flag travels with the data
    assign prod_next.last = in_beat.last;

    // only the valid flag needs a reset
    always_ff @(posedge clock) begin
        if (!resetn) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    // payload only moves when a beat arrives, so idle cycles keep it still
    always_ff @(posedge clock) begin
        if (in_valid) begin
            prod_beat <= prod_next;
        end
    end

endmodule

//--- logic/beam_sum_stage.sv
/*
  second pipeline stage, adds the weighted channels lane by lane
  each component is clamped to the signed sample range separately
  one cycle latency, never stalls
*/
`include "beam_defines.svh"

module beam_sum_stage (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       prod_valid,
    input  beam_pkg::weighted_beat_t   prod_beat,
    output logic                       sum_valid,
    output beam_pkg::beam_beat_t       sum_beat
);

    localparam int SUM_W = `BEAM_SUM_W;
    localparam int SAMPLE_W = `BEAM_SAMPLE_W;

    typedef logic signed [SUM_W-1:0] sum_t;

    beam_pkg::beam_beat_t sum_next;

    // clamp a channel sum into the sample range
    // the value fits when every bit above the sample sign bit copies the sign
    function automatic logic signed [SAMPLE_W-1:0] saturate(input sum_t v);
        if (v[SUM_W-1:SAMPLE_W-1] == {(SUM_W - SAMPLE_W + 1){v[SUM_W-1]}}) begin
            return v[SAMPLE_W-1:0];
        end else if (v[SUM_W-1]) begin
            return {1'b1, {(SAMPLE_W - 1){1'b0}}};
        end else begin
            return {1'b0, {(SAMPLE_W - 1){1'b1}}};
        end
    endfunction

    for (genvar l = 0; l < `BEAM_LANES; l++) begin : g_lane
        sum_t sum_re;
        sum_t sum_im;

        // sign extend each product to the sum width and accumulate
        always_comb begin
            sum_re = '0;
            sum_im = '0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                sum_re = sum_re + sum_t'(prod_beat.prod[c][l].re);
                sum_im = sum_im + sum_t'(prod_beat.prod[c][l].im);
            end
        end

        assign sum_next.lane[l].re = saturate(sum_re);
        assign sum_next.lane[l].im = saturate(sum_im);
    end

    assign sum_next.last = prod_beat.last;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (prod_valid) begin
            sum_beat <= sum_next;
        end
    end

endmodule

//--- logic/beam_out_queue.sv
/*
  output queue with credit flow control on both sides
  writes are never refused because upstream credits keep the occupancy in range
  a beat leaves only while a downstream credit is held
  in_credit follows each departure by one cycle
*/
`include "beam_defines.svh"

module beam_out_queue (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   sum_valid,
    input  beam_pkg::beam_beat_t   sum_beat,
    input  logic                   out_credit,
    output logic                   out_valid,
    output beam_pkg::beam_beat_t   out_beat,
    output logic                   in_credit
);

    localparam int DEPTH = `BEAM_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`BEAM_OUT_CREDITS + 1);

    beam_pkg::beam_beat_t mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              pop;

    // a beat leaves when one is stored and downstream has room for it
    assign pop = (count != '0) && (credits != '0);

    // entries hold meaning only while the count covers them
    always_ff @(posedge clock) begin
        if (sum_valid) begin
            mem[wr_ptr] <= sum_beat;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (sum_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous write and read leave the occupancy unchanged
            case ({sum_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a credit returned in the same cycle as a pop cancels it in the downstream count
    always_ff @(posedge clock) begin
        if (!resetn) begin
            credits <= CRED_W'(`BEAM_OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // the output register shows each popped beat for exactly one valid cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            // the freed entry goes back to upstream the cycle after its beat is shown
            in_credit <= out_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            out_beat <= mem[rd_ptr];
        end
    end

endmodule

//--- logic/beam_combiner.sv
/*
  four channel complex beamforming combiner
  weight stage, sum stage and output queue in a straight chain
  upstream starts with one credit per queue entry and must not send without one
  weights must stay constant while beats are in flight
*/

module beam_combiner (
    input  logic                    clock,
    input  logic                    resetn,
    input  beam_pkg::weight_set_t   weights,
    input  logic                    in_valid,
    input  beam_pkg::array_beat_t   in_beat,
    output logic                    in_credit,
    output logic                    out_valid,
    output beam_pkg::beam_beat_t    out_beat,
    input  logic                    out_credit
);

    // weighted products, one cycle after the input edge
    logic                     prod_valid;
    beam_pkg::weighted_beat_t prod_beat;

    // saturated channel sums, one cycle later
    logic                     sum_valid;
    beam_pkg::beam_beat_t     sum_beat;

    beam_weight_stage i_weight_stage (
        .clock      (clock),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .weights    (weights),
        .prod_valid (prod_valid),
        .prod_beat  (prod_beat)
    );

    beam_sum_stage i_sum_stage (
        .clock      (clock),
        .resetn     (resetn),
        .prod_valid (prod_valid),
        .prod_beat  (prod_beat),
        .sum_valid  (sum_valid),
        .sum_beat   (sum_beat)
    );

    // the queue closes the credit loop on both sides
    beam_out_queue i_out_queue (
        .clock      (clock),
        .resetn     (resetn),
        .sum_valid  (sum_valid),
        .sum_beat   (sum_beat),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .in_credit  (in_credit)
    );

endmodule

//--- sim/beam_combiner_tb.sv
/*
  directed testbench for the beamforming combiner
  inputs change on the falling edge, outputs are sampled there too
  acts as upstream and downstream credit holder and stops at the first mismatch
*/
`include "beam_defines.svh"

module beam_combiner_tb;

    localparam int DEPTH = `BEAM_QUEUE_DEPTH;
    localparam int MAX_CYCLES = 4000;

    logic                  clock;
    logic                  resetn;
    beam_pkg::weight_set_t weights;
    logic                  in_valid;
    beam_pkg::array_beat_t in_beat;
    logic                  in_credit;
    logic                  out_valid;
    beam_pkg::beam_beat_t  out_beat;
    logic                  out_credit;

    // expected output beats in input order
    beam_pkg::beam_beat_t exp_q[$];
    int out_times[$];
    int cycles = 0;
    int up_credits = DEPTH;
    int credit_pulses = 0;
    int beats_out = 0;
    // downstream credits not yet returned while hold keeps them back
    int owed = 0;
    bit hold = 0;
    logic last_out_valid = 1'b0;

    beam_combiner i_beam_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .weights    (weights),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_beat(input string name, input beam_pkg::beam_beat_t exp,
                              input beam_pkg::beam_beat_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    // integer division truncates toward zero and a negative remainder steps the quotient down
    function automatic int floor_div128(input int v);
        int q;
        q = v / 128;
        if ((v % 128 != 0) && (v < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic logic [`BEAM_SAMPLE_W-1:0] clamp16(input int v);
        if (v > 32767) begin
            return 16'h7fff;
        end else if (v < -32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    // reference model of the weighted channel sum
    function automatic beam_pkg::beam_beat_t model_beat(input beam_pkg::array_beat_t b,
                                                        input beam_pkg::weight_set_t w);
        beam_pkg::beam_beat_t r;
        int xr;
        int xi;
        int wr;
        int wi;
        int sr;
        int si;
        r.last = b.last;
        for (int l = 0; l < `BEAM_LANES; l++) begin
            sr = 0;
            si = 0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                xr = int'(b.chan[c].lane[l].re);
                xi = int'(b.chan[c].lane[l].im);
                wr = int'(w.chan[c].re);
                wi = int'(w.chan[c].im);
                sr = sr + floor_div128(xr * wr - xi * wi);
                si = si + floor_div128(xr * wi + xi * wr);
            end
            r.lane[l].re = clamp16(sr);
            r.lane[l].im = clamp16(si);
        end
        return r;
    endfunction

    function automatic beam_pkg::array_beat_t random_beat(input logic last);
        beam_pkg::array_beat_t b;
        logic [31:0] r;
        b.last = last;
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            for (int l = 0; l < `BEAM_LANES; l++) begin
                r = $urandom;
                b.chan[c].lane[l].re = r[15:0];
                b.chan[c].lane[l].im = r[31:16];
            end
        end
        return b;
    endfunction

    // advances one falling edge while it collects credits and checks any output beat
    task automatic next_cycle();
        @(negedge clock);
        cycles++;
        if (cycles > MAX_CYCLES) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
        in_valid = 1'b0;
        // each departure returns its upstream credit one cycle later
        check_bit("in_credit", last_out_valid, in_credit);
        last_out_valid = out_valid;
        if (in_credit) begin
            up_credits++;
            credit_pulses++;
        end
        if (up_credits > DEPTH) begin
            abort_run("upstream received more credits than the queue has entries");
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("an output beat arrived while none was expected");
            end
            check_beat("out_beat", exp_q.pop_front(), out_beat);
            beats_out++;
            owed++;
            out_times.push_back(cycles);
        end
        // each received beat frees one downstream slot
        if (!hold && owed > 0) begin
            out_credit = 1'b1;
            owed--;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic send_beat(input beam_pkg::array_beat_t b);
        next_cycle();
        while (up_credits == 0) begin
            next_cycle();
        end
        in_valid = 1'b1;
        in_beat = b;
        up_credits--;
        exp_q.push_back(model_beat(b, weights));
    endtask

    // waits until every beat is out and every credit is home on both sides
    task automatic drain_pipeline();
        next_cycle();
        while (exp_q.size() != 0 || owed != 0 || up_credits != DEPTH) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            next_cycle();
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("in_credit", 1'b0, in_credit);
        end
    endtask

    task automatic unit_weight_stream();
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            weights.chan[c].re = 8'sd127;
            weights.chan[c].im = 8'sd0;
        end
        for (int i = 0; i < 6; i++) begin
            send_beat(random_beat(i == 5));
        end
        drain_pipeline();
    endtask

    task automatic random_weight_stream();
        logic [31:0] r;
        r = $urandom;
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            weights.chan[c].re = r[8*c +: 8];
            weights.chan[c].im = ~r[8*c +: 8];
        end
        // most negative weight on channel 0 exercises the floor shift hardest
        weights.chan[0].re = 8'h80;
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            send_beat(random_beat(r[0]));
        end
        drain_pipeline();
    endtask

    // full scale on every channel pushes each lane past the 16-bit range
    task automatic saturation_extremes();
        beam_pkg::array_beat_t b;
        b.last = 1'b1;
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            for (int l = 0; l < `BEAM_LANES; l++) begin
                b.chan[c].lane[l].re = (l % 2 == 0) ? 16'h7fff : 16'h8000;
                b.chan[c].lane[l].im = (l % 2 == 0) ? 16'h7fff : 16'h8000;
            end
            weights.chan[c].re = 8'sd127;
            weights.chan[c].im = 8'sd0;
        end
        send_beat(b);
        drain_pipeline();
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            weights.chan[c].re = 8'h80;
        end
        send_beat(b);
        drain_pipeline();
    endtask

    task automatic backpressure_hold();
        int base_out;
        int base_pulses;
        base_out = beats_out;
        base_pulses = credit_pulses;
        hold = 1'b1;
        for (int i = 0; i < 5; i++) begin
            send_beat(random_beat(i == 4));
        end
        repeat (5) next_cycle();
        check_count("beats out under back-pressure", `BEAM_OUT_CREDITS, beats_out - base_out);
        repeat (20) begin
            next_cycle();
            check_bit("out_valid", 1'b0, out_valid);
        end
        hold = 1'b0;
        drain_pipeline();
        check_count("beats out after release", 5, beats_out - base_out);
        check_count("in_credit pulses", 5, credit_pulses - base_pulses);
    endtask

    // the first output follows the input edge by the weight, sum and queue write cycles
    // and the output register
    task automatic back_to_back_stream();
        int send_cycle;
        send_cycle = 0;
        out_times.delete();
        for (int i = 0; i < DEPTH; i++) begin
            send_beat(random_beat(i == DEPTH - 1));
            if (i == 0) begin
                send_cycle = cycles;
            end
        end
        drain_pipeline();
        check_count("output count", DEPTH, out_times.size());
        check_count("first output latency", 4, out_times[0] - send_cycle);
        check_count("output spacing", DEPTH - 1, out_times[DEPTH-1] - out_times[0]);
    endtask

    initial begin
        void'($urandom(32'ha6c4));
        resetn = 1'b0;
        weights = '0;
        in_valid = 1'b0;
        in_beat = '0;
        out_credit = 1'b0;
        repeat (4) @(negedge clock);
        resetn = 1'b1;
        idle_after_reset();
        unit_weight_stream();
        random_weight_stream();
        saturation_extremes();
        backpressure_hold();
        back_to_back_stream();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/beam_pkg.sv
logic/beam_weight_stage.sv
logic/beam_sum_stage.sv
logic/beam_out_queue.sv
logic/beam_combiner.sv
sim/beam_combiner_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the beamforming combiner testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f list.f --top-module beam_combiner_tb \
    --Mdir "$BUILD_DIR" -o beam_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/beam_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "run passed"
    exit 0
else
    echo "run failed, see $LOG"
    exit 1
fi
